//--- run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module rv_core_tb -o rv_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- sim/core_patterns.txt
# test <name> <word count> <record count>, then program words from 80000000,
# then retire records as pc rd value; words and records are hex, counts decimal
test alu_basic 9 9
00500093 FFD00113 123451B7 00208233 402082B3 00117333 0011E3B3 0021C433 001124B3
80000000 01 00000005  80000004 02 FFFFFFFD  80000008 03 12345000
8000000C 04 00000002  80000010 05 00000008  80000014 06 00000005
80000018 07 12345005  8000001C 08 EDCBAFFD  80000020 09 00000001
test bypass_chain 6 6
00100093 001080B3 001080B3 00308113 401101B3 0021C233
80000000 01 00000001  80000004 01 00000002  80000008 01 00000004
8000000C 02 00000007  80000010 03 00000003  80000014 04 00000004
test mul_stall 6 6
00700093 40000137 00310113 021101B3 00118233 021082B3
80000000 01 00000007  80000004 02 40000000  80000008 02 40000003
8000000C 03 C0000015  80000010 04 C000001C  80000014 05 00000031
test branch_flush 9 7
00400093 00400113 00209463 00208663 00100193 00200213 00900293 00128333 005183B3
80000000 01 00000004  80000004 02 00000004  80000008 00 00000000
8000000C 00 00000000  80000018 05 00000009  8000001C 06 0000000D
80000020 07 00000009
test jal_jalr 10 6
00C000EF 00100293 00200313 00300393 01408167 00100293 00710433 02108067 00100293 00140513
80000000 01 80000004  8000000C 07 00000003  80000010 02 80000014
80000018 08 80000017  8000001C 00 80000020  80000024 0A 80000018
test credit_limit 8 8
00100093 00208113 001101B3 00318233 402202B3 0042E333 005373B3 0063A433
80000000 01 00000001  80000004 02 00000003  80000008 03 00000004
8000000C 04 00000008  80000010 05 00000005  80000014 06 0000000D
80000018 07 00000005  8000001C 08 00000001

//--- sim/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core_tb;

    import rv_pipe_pkg::*;

    localparam int unsigned SEED      = 32'h89da_9e0f;
    localparam int          MAX_TESTS = 16;
    localparam int          MAX_WORDS = 512;
    localparam int          MAX_RECS  = 512;
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013;     // ADDI x0,x0,0

    logic       clk;
    logic       rst_n;
    fetch_rsp_t fetch_rsp;
    fetch_req_t fetch_req;
    retire_t    retire;

    logic [8*24-1:0] test_name [MAX_TESTS];
    int              word_base [MAX_TESTS];
    int              word_cnt  [MAX_TESTS];
    int              rec_base  [MAX_TESTS];
    int              rec_cnt   [MAX_TESTS];
    logic [31:0]     words     [MAX_WORDS];
    logic [31:0]     exp_pc    [MAX_RECS];
    logic [4:0]      exp_rd    [MAX_RECS];
    logic [31:0]     exp_value [MAX_RECS];
    int              num_tests;
    int              num_words;
    int              num_recs;
    logic            loaded;

    int cur_test;
    int cur_seen;
    int cur_errors;
    int pass_count;
    int fail_count;

    logic [31:0] pend_pc  [$];                             // Requests waiting for their answer
    logic        pend_ep  [$];
    int          pend_due [$];
    int          cycle;
    int          last_due;
    int          due;
    int          outstanding;

    rv_core_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_rsp (fetch_rsp),
        .fetch_req (fetch_req),
        .retire    (retire)
    );

    always #50 clk = ~clk;

    // Words outside the program of the running test read as a no-op
    function automatic logic [31:0] mem_word(input logic [31:0] pc);
        logic [31:0] idx;
        logic [31:0] word;
        idx  = (pc - `RESET_PC) >> 2;
        word = NOP_WORD;
        if (idx < 32'(word_cnt[cur_test])) begin
            word = words[word_base[cur_test] + int'(idx)];
        end
        return word;
    endfunction

    task automatic load_patterns(output logic ok);
        int               fd;
        int               code;
        int               nw;
        int               nr;
        logic [8*24-1:0]  tok;
        logic [8*24-1:0]  name;
        logic [8*160-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        num_tests = 0;
        num_words = 0;
        num_recs  = 0;
        fd = $fopen("sim/core_patterns.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "test") begin
                    code = $fscanf(fd, "%s %d %d", name, nw, nr);
                    test_name[num_tests] = name;
                    word_base[num_tests] = num_words;
                    word_cnt[num_tests]  = nw;
                    rec_base[num_tests]  = num_recs;
                    rec_cnt[num_tests]   = nr;
                    repeat (nw) begin
                        code = $fscanf(fd, "%h", a);
                        words[num_words] = a;
                        num_words++;
                    end
                    repeat (nr) begin
                        code = $fscanf(fd, "%h %h %h", a, b, c);
                        exp_pc[num_recs]    = a;
                        exp_rd[num_recs]    = b[4:0];
                        exp_value[num_recs] = c;
                        num_recs++;
                    end
                    num_tests++;
                end else begin
                    $display("Pattern file holds an unknown line start: %0s", tok);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) begin
            ok = 1'b0;
        end
    endtask

    task automatic check_retire();
        int idx;
        idx = rec_base[cur_test] + cur_seen;
        if (retire.pc !== exp_pc[idx] || retire.rd !== exp_rd[idx] ||
            retire.value !== exp_value[idx]) begin
            $write("[ERROR] %0s record %0d expected pc=%h rd=%0d value=%h",
                   test_name[cur_test], cur_seen, exp_pc[idx], exp_rd[idx], exp_value[idx]);
            $display(" actual pc=%h rd=%0d value=%h", retire.pc, retire.rd, retire.value);
            cur_errors++;
        end
        cur_seen++;
    endtask

    task automatic run_test(input int t);
        rst_n      = 1'b0;
        cur_test   = t;
        cur_seen   = 0;
        cur_errors = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (cur_seen < rec_cnt[t]) begin
            @(posedge clk);
        end
        if (cur_errors == 0) begin
            pass_count++;
            $display("PASS %0s: %0d retires matched", test_name[t], rec_cnt[t]);
        end else begin
            fail_count++;
            $display("FAIL %0s: %0d errors", test_name[t], cur_errors);
        end
        #1;
    endtask

    // In-order instruction memory that answers 1 to 4 cycles after each request
    initial begin : fetch_memory
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            if (!rst_n) begin
                pend_pc.delete();
                pend_ep.delete();
                pend_due.delete();
                outstanding = 0;
                last_due    = cycle;
                fetch_rsp   = '0;
            end else begin
                if (fetch_req.valid) begin
                    due = cycle + 1 + int'($urandom % 4);
                    if (due <= last_due) begin
                        due = last_due + 1;                 // One answer per cycle and in order
                    end
                    last_due = due;
                    pend_pc.push_back(fetch_req.pc);
                    pend_ep.push_back(fetch_req.epoch);
                    pend_due.push_back(due);
                    outstanding++;
                    if (outstanding > `FETCH_CREDITS) begin
                        $display("Test %0s has %0d fetch requests outstanding, more than %0d",
                                 test_name[cur_test], outstanding, `FETCH_CREDITS);
                        cur_errors++;
                    end
                end
                if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                    fetch_rsp.valid = 1'b1;
                    fetch_rsp.inst  = mem_word(pend_pc[0]);
                    fetch_rsp.pc    = pend_pc[0];
                    fetch_rsp.epoch = pend_ep[0];
                    pend_pc.delete(0);
                    pend_ep.delete(0);
                    pend_due.delete(0);
                    outstanding--;                          // Captured by decode at the next edge
                end else begin
                    fetch_rsp = '0;
                end
                if (retire.valid && cur_seen < rec_cnt[cur_test]) begin
                    check_retire();
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = num_recs * 60 + num_tests * 10;
        repeat (limit) @(posedge clk);
        $display("Timeout: retire records still missing after %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

    initial begin : main_sequence
        logic ok;
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_rsp   = '0;
        cur_test    = 0;
        cur_seen    = 0;
        cur_errors  = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycle       = 0;
        last_due    = 0;
        outstanding = 0;
        loaded      = 1'b0;
        load_patterns(ok);
        if (!ok) begin
            $display("Pattern file sim/core_patterns.txt is missing or holds no valid tests");
            $display("tests failed");
            $finish;
        end else begin
            loaded = 1'b1;
            @(posedge clk);
            #1;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("Summary: passed %0d, failed %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

//--- source/inst_decode.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module inst_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    epoch,
    input  rv_pipe_pkg::fetch_rsp_t fetch_rsp,
    input  logic                    ex_ready,
    input  rv_pipe_pkg::redirect_t  redirect,
    output logic                    credit_ret,
    output rv_pipe_pkg::dec_op_t    dec_op
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int DEPTH = `FETCH_CREDITS;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fetch_rsp_t     buf_mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    fetch_rsp_t     head;
    logic           head_valid;
    logic           head_stale;
    logic           load_en;
    logic           pop;
    inst_u          inst;
    dec_op_t        dec_next;

    assign head       = buf_mem[rd_ptr];
    assign head_valid = (count != '0);
    assign head_stale = (head.epoch != epoch);
    assign load_en    = !redirect.valid && (!dec_op.valid || ex_ready);
    assign pop        = head_valid && (head_stale || load_en);
    assign credit_ret = pop;                                 // Used or dropped, the slot is free again

    always_ff @(posedge clk) begin
        if (fetch_rsp.valid) begin
            buf_mem[wr_ptr] <= fetch_rsp;                    // Credits guarantee room
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fetch_rsp.valid) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(fetch_rsp.valid) - (AW+1)'(pop);
        end
    end

    assign inst = head.inst;

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = 1'b1;
        dec_next.pc        = head.pc;
        dec_next.alu_op    = alu_pass_imm;                   // Unsupported words retire as a no-op
        dec_next.rs1       = inst.r.rs1;
        dec_next.rs2       = inst.r.rs2;
        dec_next.rd        = inst.r.rd;
        case (inst.r.opcode)
            op_reg: begin
                dec_next.writes_rd = 1'b1;
                if (inst.r.funct7 == f7_mul && inst.r.funct3 == f3_add) begin
                    dec_next.alu_op = alu_mul;
                end else if (inst.r.funct7 == f7_sub && inst.r.funct3 == f3_add) begin
                    dec_next.alu_op = alu_sub;
                end else if (inst.r.funct7 == f7_base) begin
                    case (inst.r.funct3)
                        f3_add:  dec_next.alu_op = alu_add;
                        f3_slt:  dec_next.alu_op = alu_slt;
                        f3_xor:  dec_next.alu_op = alu_xor;
                        f3_or:   dec_next.alu_op = alu_or;
                        f3_and:  dec_next.alu_op = alu_and;
                        default: dec_next.writes_rd = 1'b0;
                    endcase
                end else begin
                    dec_next.writes_rd = 1'b0;
                end
            end
            op_imm: begin
                dec_next.rs2 = 5'd0;                         // x0 reads zero, so the ALU sees only imm
                if (inst.i.funct3 == f3_add) begin
                    dec_next.alu_op    = alu_add;
                    dec_next.imm       = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                    dec_next.writes_rd = 1'b1;
                end
            end
            op_lui: begin
                dec_next.rs1       = 5'd0;
                dec_next.rs2       = 5'd0;
                dec_next.imm       = {inst.u.imm_31_12, 12'h000};
                dec_next.writes_rd = 1'b1;
            end
            op_branch: begin
                dec_next.rd  = 5'd0;
                dec_next.imm = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                                inst.b.imm_4_1, 1'b0};
                if (inst.b.funct3 == f3_beq) begin
                    dec_next.alu_op = alu_beq;
                end else if (inst.b.funct3 == f3_bne) begin
                    dec_next.alu_op = alu_bne;
                end else begin
                    dec_next.imm = '0;
                end
            end
            op_jal: begin
                dec_next.rs1       = 5'd0;
                dec_next.rs2       = 5'd0;
                dec_next.alu_op    = alu_jal;
                dec_next.imm       = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                                      inst.j.imm_10_1, 1'b0};
                dec_next.writes_rd = 1'b1;
            end
            op_jalr: begin
                dec_next.rs2       = 5'd0;
                dec_next.alu_op    = alu_jalr;
                dec_next.imm       = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                dec_next.writes_rd = 1'b1;
            end
            default: dec_next.rd = 5'd0;
        endcase
        if (dec_next.rd == 5'd0) begin
            dec_next.writes_rd = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_op <= '0;
        end else if (redirect.valid) begin
            dec_op.valid <= 1'b0;                            // Wrong-path op
        end else if (load_en) begin
            if (head_valid && !head_stale) begin
                dec_op <= dec_next;
            end else begin
                dec_op.valid <= 1'b0;
            end
        end
    end

endmodule

//--- source/inst_execute.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module inst_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_pipe_pkg::dec_op_t   dec_op,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output logic [4:0]             rs1_addr,
    output logic [4:0]             rs2_addr,
    output logic                   ex_ready,
    output rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::wb_t       wb
);

    import rv_isa_pkg::*;

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic             accept;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] target;
    logic             taken;
    logic [4:0]       rd_eff;
    logic [CNT_W-1:0] mul_cnt;
    logic             mul_busy;
    logic [`XLEN-1:0] mul_a;
    logic [`XLEN-1:0] mul_b;
    logic [`XLEN-1:0] mul_pc;
    logic [4:0]       mul_rd;
    logic [`XLEN-1:0] mul_prod;

    assign rs1_addr = dec_op.rs1;
    assign rs2_addr = dec_op.rs2;
    assign mul_busy = (mul_cnt != '0);
    assign ex_ready = !mul_busy && !redirect.valid;          // Redirect cycle holds a wrong-path op
    assign accept   = dec_op.valid && ex_ready;
    assign rd_eff   = dec_op.writes_rd ? dec_op.rd : 5'd0;
    assign pc_plus4 = dec_op.pc + `XLEN'd4;
    assign alu_b    = rs2_data | dec_op.imm;                 // One side is always zero
    assign mul_prod = mul_a * mul_b;                         // Low half of the product

    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = dec_op.pc + dec_op.imm;
        case (dec_op.alu_op)
            alu_add:      result = rs1_data + alu_b;
            alu_sub:      result = rs1_data - alu_b;
            alu_and:      result = rs1_data & alu_b;
            alu_or:       result = rs1_data | alu_b;
            alu_xor:      result = rs1_data ^ alu_b;
            alu_slt:      result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(alu_b)};
            alu_pass_imm: result = dec_op.imm;
            alu_beq:      taken  = (rs1_data == rs2_data);
            alu_bne:      taken  = (rs1_data != rs2_data);
            alu_jal: begin
                taken  = 1'b1;
                result = pc_plus4;
            end
            alu_jalr: begin
                taken  = 1'b1;
                target = (rs1_data + dec_op.imm) & ~`XLEN'd1;
                result = pc_plus4;
            end
            default: result = '0;                            // MUL finishes in the multiplier
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept && dec_op.alu_op == alu_mul) begin
            mul_a  <= rs1_data;
            mul_b  <= rs2_data;
            mul_pc <= dec_op.pc;
            mul_rd <= rd_eff;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_cnt  <= '0;
            wb       <= '0;
            redirect <= '0;
        end else begin
            wb.valid       <= 1'b0;
            redirect.valid <= 1'b0;
            if (mul_busy) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == CNT_W'(1)) begin
                    wb <= '{valid: 1'b1, pc: mul_pc, rd: mul_rd, value: mul_prod};
                end
            end else if (accept) begin
                if (dec_op.alu_op == alu_mul) begin
                    mul_cnt <= CNT_W'(`MUL_CYCLES - 1);
                end else begin
                    wb       <= '{valid: 1'b1, pc: dec_op.pc, rd: rd_eff, value: result};
                    redirect <= '{valid: taken && (target != pc_plus4), target: target};
                end
            end
        end
    end

endmodule

//--- source/pc_gen.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_pipe_pkg::redirect_t redirect,
    input  logic                   credit_ret,
    output rv_pipe_pkg::fetch_req_t fetch_req,
    output logic                   epoch
);

    localparam int CW = $clog2(`FETCH_CREDITS + 1);

    logic [CW-1:0]    credits;
    logic [`XLEN-1:0] pc;
    logic             issue;

    // A redirect cycle issues nothing so the next request already carries the target
    assign issue = (credits != '0) && !redirect.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CW'(`FETCH_CREDITS);
        end else begin
            credits <= credits + CW'(credit_ret) - CW'(issue); // Return and spend may coincide
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_req <= '0;
        end else begin
            fetch_req.valid <= issue;
            fetch_req.pc    <= pc;
            fetch_req.epoch <= epoch;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= `RESET_PC;
            epoch <= 1'b0;
        end else if (redirect.valid) begin
            pc    <= redirect.target;
            epoch <= ~epoch;                                  // Words still in flight become stale
        end else if (issue) begin
            pc <= pc + `XLEN'd4;                             // Always fall through
        end
    end

endmodule

//--- source/result_writeback.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module result_writeback (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::wb_t     wb,
    input  logic [4:0]           rs1_addr,
    input  logic [4:0]           rs2_addr,
    output logic [`XLEN-1:0]     rs1_data,
    output logic [`XLEN-1:0]     rs2_data,
    output rv_pipe_pkg::retire_t retire
);

    logic [`XLEN-1:0] regs [1:31];                           // x0 is not stored

    function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == 5'd0) begin
            data = '0;
        end else if (wb.valid && wb.rd == addr) begin
            data = wb.value;                                 // Pending write not yet in the file
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else begin
            retire.valid <= wb.valid;                        // Branches report rd zero
            retire.pc    <= wb.pc;
            retire.rd    <= wb.rd;
            retire.value <= wb.value;
        end
    end

endmodule

//--- source/rv_core_top.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pipe_pkg::fetch_rsp_t fetch_rsp,
    output rv_pipe_pkg::fetch_req_t fetch_req,
    output rv_pipe_pkg::retire_t    retire
);

    import rv_pipe_pkg::*;

    redirect_t        redirect;
    dec_op_t          dec_op;
    wb_t              wb;
    logic             credit_ret;
    logic             epoch;
    logic             ex_ready;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    pc_gen u_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .credit_ret (credit_ret),
        .fetch_req  (fetch_req),
        .epoch      (epoch)
    );

    inst_decode u_inst_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .epoch      (epoch),
        .fetch_rsp  (fetch_rsp),
        .ex_ready   (ex_ready),
        .redirect   (redirect),
        .credit_ret (credit_ret),
        .dec_op     (dec_op)
    );

    inst_execute u_inst_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec_op   (dec_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .ex_ready (ex_ready),
        .redirect (redirect),
        .wb       (wb)
    );

    result_writeback u_result_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .retire   (retire)
    );

endmodule

//--- source/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and address width
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h8000_0000

// Fetch requests in flight plus words held in the decode buffer never exceed this
`define FETCH_CREDITS 2

// Multiply latency from acceptance to result
`define MUL_CYCLES 3

`endif

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    localparam logic [2:0] f3_add = 3'b000; // Also ADDI, SUB and MUL
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;
    localparam logic [6:0] f7_mul  = 7'b0000001; // M extension

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        opcode_e     opcode;
    } b_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } j_fmt_t;

    // One fetched word, read through whichever format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
        b_fmt_t b;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_pass_imm, alu_mul, alu_beq, alu_bne, alu_jal, alu_jalr
    } alu_op_e;

endpackage

//--- source/rv_pipe_pkg.sv
`include "rv_defines.svh"

package rv_pipe_pkg;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             epoch;
    } fetch_req_t;

    // Memory echoes pc and epoch of the matching request
    typedef struct packed {
        logic             valid;
        logic [31:0]      inst;
        logic [`XLEN-1:0] pc;
        logic             epoch;
    } fetch_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        rv_isa_pkg::alu_op_e alu_op;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [31:0]         imm;
        logic                writes_rd;
    } dec_op_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [4:0]       rd;      // Zero when nothing is written
        logic [`XLEN-1:0] value;
    } wb_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
    } retire_t;

endpackage

//--- sources.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/pc_gen.sv
source/inst_decode.sv
source/inst_execute.sv
source/result_writeback.sv
source/rv_core_top.sv
sim/rv_core_tb.sv
